// ==== hdl/irq_defs.svh ====
// Fixed build-time constants; IRQ_NUM_SRC must stay equal to sync plus async count, stride fits 32 bits
`ifndef IRQ_DEFS_SVH
`define IRQ_DEFS_SVH

// Source counts
// Synchronous level sources occupy the low half of the combined mask
`define IRQ_NUM_SYNC 4

// Asynchronous edge sources occupy the high half
`define IRQ_NUM_ASYNC 4

// Combined source count, also the width of the pending mask
`define IRQ_NUM_SRC (`IRQ_NUM_SYNC + `IRQ_NUM_ASYNC)

// Synchronizer
// Flop depth ahead of the async edge detector, two is the usual minimum
`define IRQ_SYNC_STAGES 2

// Vector table
// Address of combined index 0
`define IRQ_VEC_BASE 32'hD000_0000

// Address step from one index to the next
`define IRQ_VEC_STRIDE 32'h0000_0080

`endif

// ==== hdl/irq_types_pkg.sv ====
// Widths follow the counts in irq_defs.svh; the combined mask keeps async bits above sync bits
`default_nettype none

`include "irq_defs.svh"

package irq_types_pkg;

    // One bit per synchronous level source
    typedef logic [`IRQ_NUM_SYNC-1:0] sync_mask_t;

    // One bit per asynchronous edge source
    typedef logic [`IRQ_NUM_ASYNC-1:0] async_mask_t;

    // Combined mask, bit index equals priority
    typedef logic [`IRQ_NUM_SRC-1:0] src_mask_t;

    // Index into the combined mask
    typedef logic [$clog2(`IRQ_NUM_SRC)-1:0] src_idx_t;

    // Vector address handed to the receiver
    typedef logic [31:0] irq_vec_t;

endpackage

`default_nettype wire

// ==== hdl/irq_fsm_pkg.sv ====
// Delivery FSM encoding only; one vector is in flight at any time
`default_nettype none

package irq_fsm_pkg;

    // Four-phase handshake states
    // DLV_IDLE  waiting for a pending source and ack low
    // DLV_REQ   req high, vector held, waiting for ack
    // DLV_DROP  req low, waiting for ack to return low
    typedef enum logic [1:0] {
        DLV_IDLE = 2'd0,
        DLV_REQ  = 2'd1,
        DLV_DROP = 2'd2
    } dlv_state_t;

endpackage

`default_nettype wire

// ==== hdl/irq_capture.sv ====
// Sync sources are level sampled every cycle; async sources count only on a synchronized rising edge
`timescale 1ns/10ps
`default_nettype none

`include "irq_defs.svh"

module irq_capture
    import irq_types_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  sync_mask_t  sync_irq,
    input  async_mask_t async_irq,
    input  src_mask_t   take,
    output src_mask_t   pending
);

    // Synchronizer chain, stage 0 samples the raw pins
    async_mask_t sync_ff [`IRQ_SYNC_STAGES];

    // Last stage output and its delayed copy
    async_mask_t async_sync;
    async_mask_t async_prev;
    async_mask_t async_edge;

    // New requests this cycle, laid out like the combined mask
    src_mask_t   set_mask;
    src_mask_t   pending_next;

    // Synchronizer for the asynchronous pins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `IRQ_SYNC_STAGES; s++) begin
                sync_ff[s] <= '0;
            end
        end else begin
            sync_ff[0] <= async_irq;
            for (int s = 1; s < `IRQ_SYNC_STAGES; s++) begin
                sync_ff[s] <= sync_ff[s-1];
            end
        end
    end

    assign async_sync = sync_ff[`IRQ_SYNC_STAGES-1];

    // Previous synchronized value for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            async_prev <= '0;
        end else begin
            async_prev <= async_sync;
        end
    end

    // Rising edge only, a held level fires once
    assign async_edge = async_sync & ~async_prev;

    // Async edges in the upper half, sync levels in the lower half
    assign set_mask = {async_edge, sync_irq};

    // Clear the served bit; a set in the same cycle wins
    assign pending_next = (pending & ~take) | set_mask;

    // Pending register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= pending_next;
        end
    end

    // Delivery may only serve a source that is actually pending here
    a_take_is_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        (take & ~pending) == '0
    ) else $error("take names a source that is not pending");

endmodule

`default_nettype wire

// ==== hdl/irq_delivery.sv ====
// Serves one source per four-phase handshake; receiver must hold ack until req falls, vector holds when idle
`timescale 1ns/10ps
`default_nettype none

`include "irq_defs.svh"

module irq_delivery
    import irq_types_pkg::*;
    import irq_fsm_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  src_mask_t  pending,
    input  wire        ack,
    output src_mask_t  take,
    output logic       req,
    output irq_vec_t   vector
);

    dlv_state_t state;

    // Highest pending index and its vector
    src_idx_t   sel_idx;
    irq_vec_t   sel_vec;
    logic       any_pending;

    // Priority encoder
    // Ascending scan, so the last set bit seen is the highest
    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < `IRQ_NUM_SRC; i++) begin
            if (pending[i]) begin
                sel_idx = src_idx_t'(i);
            end
        end
    end

    assign any_pending = |pending;

    // Vector from base and stride instead of a table
    assign sel_vec = irq_vec_t'(`IRQ_VEC_BASE)
                   + irq_vec_t'(sel_idx) * irq_vec_t'(`IRQ_VEC_STRIDE);

    // Delivery FSM with registered req, take and vector
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= DLV_IDLE;
            req    <= 1'b0;
            take   <= '0;
            vector <= '0;
        end else begin
            // take is a single-cycle pulse
            take <= '0;
            case (state)
                DLV_IDLE: begin
                    // Start only once the previous ack has been seen low
                    if (any_pending && !ack) begin
                        vector <= sel_vec;
                        take   <= src_mask_t'(1) << sel_idx;
                        req    <= 1'b1;
                        state  <= DLV_REQ;
                    end
                end
                DLV_REQ: begin
                    // Hold req and vector until the receiver answers
                    if (ack) begin
                        req   <= 1'b0;
                        state <= DLV_DROP;
                    end
                end
                DLV_DROP: begin
                    // Wait for the receiver to release ack
                    if (!ack) begin
                        state <= DLV_IDLE;
                    end
                end
                default: begin
                    req   <= 1'b0;
                    state <= DLV_IDLE;
                end
            endcase
        end
    end

    // At most one source served per cycle
    a_take_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(take)
    ) else $error("take is not one-hot");

    // Receiver may sample vector at any point of req high
    a_vector_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req && $past(req)) |-> (vector == $past(vector))
    ) else $error("vector changed while req high");

    // New request only after ack was seen low
    a_no_req_on_ack: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(req) |-> !$past(ack)
    ) else $error("req rose while ack high");

endmodule

`default_nettype wire

// ==== hdl/irq_ctrl_top.sv ====
// Top of the vector controller; ack must follow the four-phase protocol, async pins may be fully asynchronous
`timescale 1ns/10ps
`default_nettype none

module irq_ctrl_top
    import irq_types_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  sync_mask_t  sync_irq,
    input  async_mask_t async_irq,
    input  wire         ack,
    output logic        req,
    output irq_vec_t    vector
);

    // Pending mask from capture to delivery
    src_mask_t pending;

    // Served source, back from delivery to capture
    src_mask_t take;

    // Synchronizer, edge detection and pending register
    irq_capture u_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .sync_irq  (sync_irq),
        .async_irq (async_irq),
        .take      (take),
        .pending   (pending)
    );

    // Priority select, vector and handshake
    irq_delivery u_delivery (
        .clk     (clk),
        .rst_n   (rst_n),
        .pending (pending),
        .ack     (ack),
        .take    (take),
        .req     (req),
        .vector  (vector)
    );

endmodule

`default_nettype wire

// ==== bench/irq_ctrl_tb.sv ====
// Drives inputs on the falling edge; async edges are settled while a request is in flight
`timescale 1ns/10ps
`default_nettype none

`include "irq_defs.svh"

module irq_ctrl_tb
    import irq_types_pkg::*;
();

    localparam int WAIT_LIMIT = 64;
    // Async edge needs the synchronizer depth plus detect and pending edges
    localparam int SETTLE = `IRQ_SYNC_STAGES + 2;

    logic        clk;
    logic        rst_n;
    sync_mask_t  sync_irq;
    async_mask_t async_irq;
    logic        ack;
    logic        req;
    irq_vec_t    vector;

    // Reference model state
    src_mask_t   exp_pending;
    src_mask_t   exp_hold;
    async_mask_t async_q;
    logic        req_q;
    logic        delivered;
    logic        drained;
    irq_vec_t    exp_vec;
    src_idx_t    seen_idx;
    logic [15:0] lfsr;

    irq_ctrl_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .sync_irq  (sync_irq),
        .async_irq (async_irq),
        .ack       (ack),
        .req       (req),
        .vector    (vector)
    );

    always #10 clk = ~clk;

    // Galois LFSR, 16 bits, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Highest set bit wins, async 3 down to sync 0
    function automatic src_idx_t top_index(input src_mask_t m);
        for (int i = `IRQ_NUM_SRC - 1; i >= 0; i--) begin
            if (m[i]) begin
                return src_idx_t'(i);
            end
        end
        return '0;
    endfunction

    function automatic irq_vec_t vector_of(input src_idx_t idx);
        return `IRQ_VEC_BASE + irq_vec_t'(idx) * `IRQ_VEC_STRIDE;
    endfunction

    task automatic report_failure(input string what);
        $display("%0t %s", $time, what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // One LFSR step per bit taken
    task automatic random_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic pulse_sync(input sync_mask_t m);
        @(negedge clk) sync_irq = m;
        @(negedge clk) sync_irq = '0;
    endtask

    task automatic wait_for_req();
        int n;
        n = 0;
        while (!req && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!req) report_failure("timed out waiting for req to rise");
    endtask

    // Receiver side, random delay of 0 to 7 cycles before ack rises and before it falls
    task automatic answer_req();
        logic [7:0] d;
        int         n;
        random_bits(3, d);
        repeat (d) @(negedge clk);
        @(negedge clk) ack = 1'b1;
        n = 0;
        while (req && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (req) report_failure("timed out waiting for req to fall after ack");
        // Late release of ack keeps delivery parked in DLV_DROP
        random_bits(3, d);
        repeat (d) @(negedge clk);
        ack = 1'b0;
    endtask

    task automatic serve_one();
        wait_for_req();
        answer_req();
    endtask

    task automatic serve_all();
        while (exp_pending != '0) begin
            serve_one();
        end
    endtask

    // Async first so its edges settle while the first handshake is held off
    task automatic send_burst(input sync_mask_t s, input async_mask_t a);
        if (a != '0) begin
            @(negedge clk) async_irq = a;
            wait_for_req();
            sync_irq = s;
            @(negedge clk) sync_irq = '0;
            async_irq = '0;
            idle_cycles(SETTLE);
            answer_req();
        end else if (s != '0) begin
            pulse_sync(s);
        end
        serve_all();
    endtask

    // Model: set from applied levels and edges, clear the served index at req rise
    assign exp_vec  = vector_of(top_index(exp_hold));
    assign seen_idx = src_idx_t'((vector - `IRQ_VEC_BASE) / `IRQ_VEC_STRIDE);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_pending <= '0;
            exp_hold    <= '0;
            async_q     <= '0;
            req_q       <= 1'b0;
            delivered   <= 1'b0;
        end else begin
            exp_hold <= exp_pending;
            req_q    <= req;
            async_q  <= async_irq;
            if (req && !req_q) begin
                delivered   <= 1'b1;
                exp_pending <= (exp_pending & ~(src_mask_t'(1) << seen_idx))
                             | {async_irq & ~async_q, sync_irq};
            end else begin
                exp_pending <= exp_pending | {async_irq & ~async_q, sync_irq};
            end
        end
    end

    // Nothing delivered yet means vector still at its reset value
    a_reset_vector: assert property (@(posedge clk) disable iff (!rst_n)
        (!req && !delivered) |-> vector == '0)
        else report_mismatch("vector", '0, $sampled(vector));

    a_vector_expected: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |-> vector == exp_vec)
        else report_mismatch("vector", $sampled(exp_vec), $sampled(vector));

    a_req_has_source: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |-> exp_hold != '0)
        else report_failure("req rose with no source pending");

    a_vector_held: assert property (@(posedge clk) disable iff (!rst_n)
        (req && $past(req)) |-> $stable(vector))
        else report_failure("vector changed while req was high");

    a_req_falls_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |-> $past(ack))
        else report_failure("req fell before ack was seen");

    a_no_rise_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) |-> !$past(ack))
        else report_failure("req rose while ack was high");

    a_all_served: assert property (@(posedge clk) disable iff (!rst_n)
        drained |-> (!req && exp_pending == '0))
        else report_failure("sources left undelivered at the end");

    initial begin
        logic [7:0] r;
        logic [7:0] s;
        clk       = 1'b0;
        rst_n     = 1'b0;
        sync_irq  = '0;
        async_irq = '0;
        ack       = 1'b0;
        drained   = 1'b0;
        lfsr      = 16'd2;
        repeat (16) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;
        // Quiet after reset
        idle_cycles(10);
        // Each sync source alone, no repeat once the level drops
        for (int i = 0; i < `IRQ_NUM_SYNC; i++) begin
            pulse_sync(sync_mask_t'(1) << i);
            serve_one();
            idle_cycles(12);
        end
        // All sources together, descending order
        send_burst('1, '1);
        idle_cycles(5);
        // Held async level fires once, a new edge fires again
        random_bits(2, r);
        @(negedge clk) async_irq = async_mask_t'(1) << r[1:0];
        serve_one();
        idle_cycles(20);
        async_irq = '0;
        idle_cycles(SETTLE);
        async_irq = async_mask_t'(1) << r[1:0];
        serve_one();
        async_irq = '0;
        idle_cycles(5);
        // Sync source re-asserted while its request is in flight
        random_bits(2, r);
        @(negedge clk) sync_irq = sync_mask_t'(1) << r[1:0];
        wait_for_req();
        sync_irq = '0;
        pulse_sync(sync_mask_t'(1) << r[1:0]);
        answer_req();
        serve_all();
        // Same for an async source with a fresh edge
        random_bits(2, r);
        @(negedge clk) async_irq = async_mask_t'(1) << r[1:0];
        wait_for_req();
        async_irq = '0;
        @(negedge clk) async_irq = async_mask_t'(1) << r[1:0];
        idle_cycles(SETTLE);
        async_irq = '0;
        answer_req();
        serve_all();
        // Random patterns under random ack delays
        repeat (12) begin
            random_bits(4, s);
            random_bits(4, r);
            send_burst(s[3:0], r[3:0]);
            idle_cycles(3);
        end
        idle_cycles(20);
        drained = 1'b1;
        idle_cycles(4);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/irq_types_pkg.sv
hdl/irq_fsm_pkg.sv
hdl/irq_capture.sv
hdl/irq_delivery.sv
hdl/irq_ctrl_top.sv
bench/irq_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= irq_ctrl_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, not the simulator exit status
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All tests passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
